// File: rtl/rv_exec_settings.svh
`ifndef RV_EXEC_SETTINGS_SVH
`define RV_EXEC_SETTINGS_SVH

// integer register and address width of the core.
`define XLEN 64

// immediates arrive from decode in this width and are sign-extended in execute.
`define IMM_W 32

// destination register index.
`define REG_ADDR_W 5

// low half of a register, the operand width of the RV64 word operations.
`define WORD_W 32

`define SHAMT_W 6       // shift amount bits for full-width shifts.
`define WORD_SHAMT_W 5  // shift amount bits for word shifts.

// one write strobe per byte of a register.
`define STRB_W (`XLEN / 8)

// byte offset inside a double word, as seen by the store lanes.
`define BYTE_OFS_W 3

`endif

// File: rtl/rv_exec_pkg.sv
`include "rv_exec_settings.svh"

package rv_exec_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    typedef enum logic {
        A_SRC1 = 1'b0,
        A_PC   = 1'b1
    } a_sel_e;

    // the fourth code is not used by decode.
    typedef enum logic [1:0] {
        B_SRC2 = 2'd0,
        B_FOUR = 2'd1,
        B_IMM  = 2'd2
    } b_sel_e;

    typedef enum logic [3:0] {
        BR_NONE = 4'd0,
        BR_JAL  = 4'd1,
        BR_JALR = 4'd2,
        BR_BEQ  = 4'd3,
        BR_BNE  = 4'd4,
        BR_BLT  = 4'd5,
        BR_BGE  = 4'd6,
        BR_BLTU = 4'd7,
        BR_BGEU = 4'd8
    } branch_e;

    typedef enum logic [1:0] {
        MEM_B = 2'd0,
        MEM_H = 2'd1,
        MEM_W = 2'd2,
        MEM_D = 2'd3
    } mem_size_e;

    typedef struct packed {
        logic [`XLEN-1:0]       src1;
        logic [`XLEN-1:0]       src2;
        logic [`IMM_W-1:0]      imm;
        logic [`XLEN-1:0]       pc;
        logic [`REG_ADDR_W-1:0] rd;
        a_sel_e                 a_sel;
        b_sel_e                 b_sel;
        alu_op_e                alu_op;
        logic                   is_word;
        branch_e                branch;
        mem_size_e              mem_size;
        logic                   mem_rd;
        logic                   mem_wr;
        logic                   reg_wr;
        logic                   ecall;
        logic                   error;  // fault flagged by decode, carried to memory.
    } issue_t;

    typedef struct packed {
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       result;
        logic [`XLEN-1:0]       next_pc;
        logic                   taken;
        logic [`REG_ADDR_W-1:0] rd;
        logic                   reg_wr;
        logic                   mem_rd;
        logic                   mem_wr;
        logic [`STRB_W-1:0]     wmask;
        logic [`XLEN-1:0]       wdata;
        logic                   ecall;
        logic                   error;
    } ex_result_t;

endpackage

// File: rtl/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n,
    input  logic     block,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // a bubble loads as valid low, so a stale payload never looks live.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (!block) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!block) begin
            out_data <= in_data;  // held as is for every cycle of block.
        end
    end

endmodule

// File: rtl/int_alu.sv
`timescale 1ns/1ps
`include "rv_exec_settings.svh"

module int_alu import rv_exec_pkg::*; (
    input  logic [`XLEN-1:0] a,
    input  logic [`XLEN-1:0] b,
    input  alu_op_e          op,
    input  logic             is_word,
    output logic [`XLEN-1:0] result
);

    logic [`XLEN-1:0]         res_d;
    logic [`WORD_W-1:0]       res_w;
    logic [`WORD_W-1:0]       a_w;
    logic [`WORD_W-1:0]       b_w;
    logic [`SHAMT_W-1:0]      sh_d;
    logic [`WORD_SHAMT_W-1:0] sh_w;
    logic                     lt_d;
    logic                     ltu_d;
    logic                     lt_w;
    logic                     ltu_w;

    assign a_w  = a[`WORD_W-1:0];
    assign b_w  = b[`WORD_W-1:0];
    assign sh_d = b[`SHAMT_W-1:0];
    assign sh_w = b[`WORD_SHAMT_W-1:0];

    assign lt_d  = $signed(a) < $signed(b);
    assign ltu_d = a < b;
    assign lt_w  = $signed(a_w) < $signed(b_w);
    assign ltu_w = a_w < b_w;

    always_comb begin
        case (op)
            ALU_ADD:  res_d = a + b;
            ALU_SUB:  res_d = a - b;
            ALU_SLL:  res_d = a << sh_d;
            ALU_SLT:  res_d = {{(`XLEN-1){1'b0}}, lt_d};
            ALU_SLTU: res_d = {{(`XLEN-1){1'b0}}, ltu_d};
            ALU_XOR:  res_d = a ^ b;
            ALU_SRL:  res_d = a >> sh_d;
            ALU_SRA:  res_d = $unsigned($signed(a) >>> sh_d);
            ALU_OR:   res_d = a | b;
            ALU_AND:  res_d = a & b;
            default:  res_d = '0;
        endcase
    end

    // word variants only look at the low halves; sra shifts in bit 31.
    always_comb begin
        case (op)
            ALU_ADD:  res_w = a_w + b_w;
            ALU_SUB:  res_w = a_w - b_w;
            ALU_SLL:  res_w = a_w << sh_w;
            ALU_SLT:  res_w = {{(`WORD_W-1){1'b0}}, lt_w};
            ALU_SLTU: res_w = {{(`WORD_W-1){1'b0}}, ltu_w};
            ALU_XOR:  res_w = a_w ^ b_w;
            ALU_SRL:  res_w = a_w >> sh_w;
            ALU_SRA:  res_w = $unsigned($signed(a_w) >>> sh_w);
            ALU_OR:   res_w = a_w | b_w;
            ALU_AND:  res_w = a_w & b_w;
            default:  res_w = '0;
        endcase
    end

    assign result = is_word ? {{(`XLEN-`WORD_W){res_w[`WORD_W-1]}}, res_w} : res_d;

endmodule

// File: rtl/branch_unit.sv
`timescale 1ns/1ps
`include "rv_exec_settings.svh"

module branch_unit import rv_exec_pkg::*; (
    input  branch_e          kind,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] src1,
    input  logic [`XLEN-1:0] src2,
    input  logic [`XLEN-1:0] imm,
    output logic             taken,
    output logic [`XLEN-1:0] next_pc
);

    logic             eq;
    logic             lt_s;
    logic             lt_u;
    logic             cond;
    logic [`XLEN-1:0] pc_imm;
    logic [`XLEN-1:0] jalr_tgt;

    assign eq       = src1 == src2;
    assign lt_s     = $signed(src1) < $signed(src2);
    assign lt_u     = src1 < src2;
    assign pc_imm   = pc + imm;
    assign jalr_tgt = (src1 + imm) & ~{{(`XLEN-1){1'b0}}, 1'b1};  // bit zero cleared.

    always_comb begin
        case (kind)
            BR_JAL, BR_JALR: cond = 1'b1;
            BR_BEQ:          cond = eq;
            BR_BNE:          cond = !eq;
            BR_BLT:          cond = lt_s;
            BR_BGE:          cond = !lt_s;
            BR_BLTU:         cond = lt_u;
            BR_BGEU:         cond = !lt_u;
            default:         cond = 1'b0;
        endcase
    end

    assign taken   = cond;
    assign next_pc = !cond ? pc + `XLEN'd4 : (kind == BR_JALR) ? jalr_tgt : pc_imm;

endmodule

// File: rtl/store_align.sv
`timescale 1ns/1ps
`include "rv_exec_settings.svh"

module store_align import rv_exec_pkg::*; (
    input  mem_size_e              size,
    input  logic [`BYTE_OFS_W-1:0] addr_low,
    input  logic [`XLEN-1:0]       data,
    output logic [`STRB_W-1:0]     wmask,
    output logic [`XLEN-1:0]       wdata
);

    // the low bytes are copied to every lane, the mask picks the lane that is written.
    always_comb begin
        case (size)
            MEM_B: begin
                wdata = {8{data[7:0]}};
                wmask = `STRB_W'(8'h01) << addr_low;
            end
            MEM_H: begin
                wdata = {4{data[15:0]}};
                wmask = `STRB_W'(8'h03) << {addr_low[2:1], 1'b0};  // halfword aligned lanes.
            end
            MEM_W: begin
                wdata = {2{data[31:0]}};
                wmask = `STRB_W'(8'h0f) << {addr_low[2], 2'b00};
            end
            default: begin
                wdata = data;
                wmask = '1;
            end
        endcase
    end

endmodule

// File: rtl/exec_stage.sv
`timescale 1ns/1ps
`include "rv_exec_settings.svh"

module exec_stage import rv_exec_pkg::*; (
    input  issue_t     item,
    input  logic       in_valid,
    input  logic       raise_intr,
    output ex_result_t out,
    output logic       out_valid
);

    logic [`XLEN-1:0]   imm_x;
    logic [`XLEN-1:0]   op_a;
    logic [`XLEN-1:0]   op_b;
    logic [`XLEN-1:0]   alu_result;
    logic               br_taken;
    logic [`XLEN-1:0]   br_next_pc;
    logic [`STRB_W-1:0] st_wmask;
    logic [`XLEN-1:0]   st_wdata;

    assign imm_x = {{(`XLEN-`IMM_W){item.imm[`IMM_W-1]}}, item.imm};
    assign op_a  = (item.a_sel == A_PC) ? item.pc : item.src1;

    always_comb begin
        case (item.b_sel)
            B_SRC2:  op_b = item.src2;
            B_FOUR:  op_b = `XLEN'd4;
            B_IMM:   op_b = imm_x;
            default: op_b = '0;
        endcase
    end

    int_alu u_alu (
        .a       (op_a),
        .b       (op_b),
        .op      (item.alu_op),
        .is_word (item.is_word),
        .result  (alu_result)
    );

    branch_unit u_branch (
        .kind    (item.branch),
        .pc      (item.pc),
        .src1    (item.src1),
        .src2    (item.src2),
        .imm     (imm_x),
        .taken   (br_taken),
        .next_pc (br_next_pc)
    );

    // stores are decoded as src1 plus imm, so the ALU sum is the store address.
    store_align u_store (
        .size     (item.mem_size),
        .addr_low (alu_result[`BYTE_OFS_W-1:0]),
        .data     (item.src2),
        .wmask    (st_wmask),
        .wdata    (st_wdata)
    );

    // an interrupt kills the instruction here, except an ecall which must trap itself.
    assign out_valid = in_valid && (item.ecall || !raise_intr);

    always_comb begin
        out.pc      = item.pc;
        out.result  = alu_result;
        out.next_pc = br_next_pc;
        out.taken   = br_taken && out_valid;  // a bubble or a killed slot never redirects.
        out.rd      = item.rd;
        out.reg_wr  = item.reg_wr;
        out.mem_rd  = item.mem_rd;
        out.mem_wr  = item.mem_wr;
        out.wmask   = st_wmask;
        out.wdata   = st_wdata;
        out.ecall   = item.ecall;
        out.error   = item.error;
    end

endmodule

// File: rtl/exec_top.sv
`timescale 1ns/1ps

module exec_top import rv_exec_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       block,
    input  logic       issue_valid,
    input  issue_t     issue,
    input  logic       raise_intr,
    output logic       mem_valid,
    output ex_result_t mem
);

    issue_t     ex_item;
    logic       ex_valid;
    ex_result_t ex_out;
    logic       ex_out_valid;

    stage_reg #(.payload_t(issue_t)) u_issue (
        .clk       (clk),
        .arst_n    (arst_n),
        .block     (block),
        .in_valid  (issue_valid),
        .in_data   (issue),
        .out_valid (ex_valid),
        .out_data  (ex_item)
    );

    exec_stage u_exec (
        .item       (ex_item),
        .in_valid   (ex_valid),
        .raise_intr (raise_intr),
        .out        (ex_out),
        .out_valid  (ex_out_valid)
    );

    // both registers share block, so the whole slice stalls as one.
    stage_reg #(.payload_t(ex_result_t)) u_result (
        .clk       (clk),
        .arst_n    (arst_n),
        .block     (block),
        .in_valid  (ex_out_valid),
        .in_data   (ex_out),
        .out_valid (mem_valid),
        .out_data  (mem)
    );

endmodule

// File: bench/exec_checker.sv
`timescale 1ns/1ps

module exec_checker import rv_exec_pkg::*; (
    input logic       clk,
    input logic       arst_n,
    input logic       block,
    input logic       mem_valid,
    input ex_result_t mem
);

    // the result register comes out of reset empty.
    reset_empty: assert property (@(posedge clk) !arst_n |-> !mem_valid)
        else $error("mem_valid high during reset");

    // a blocked slice holds its output exactly.
    block_holds: assert property (@(posedge clk) disable iff (!arst_n)
        block |=> $stable(mem_valid) && $stable(mem))
        else $error("mem output changed while block was high");

    taken_is_valid: assert property (@(posedge clk) disable iff (!arst_n)
        mem.taken |-> mem_valid)
        else $error("mem.taken high without mem_valid");

endmodule

bind exec_top exec_checker u_checker (
    .clk       (clk),
    .arst_n    (arst_n),
    .block     (block),
    .mem_valid (mem_valid),
    .mem       (mem)
);

// File: bench/exec_tb.sv
`timescale 1ns/1ps
`include "rv_exec_settings.svh"

module exec_tb import rv_exec_pkg::*; ();

    localparam int CMP_W   = $bits(ex_result_t);
    localparam int N_ALU   = 500;
    localparam int N_CTRL  = 200;
    localparam int N_STORE = 32;
    localparam int N_STALL = 300;
    localparam int N_INTR  = 300;
    localparam int N_ISSUE = N_ALU + N_CTRL + N_STORE + N_STALL + N_INTR;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       block;
    logic       issue_valid;
    issue_t     issue;
    logic       raise_intr;
    logic       mem_valid;
    ex_result_t mem;

    integer     seed = 32'hed7ed410;
    string      test_name = "reset";
    int         errors = 0;
    int         err_start = 0;
    int         checks = 0;
    int         sent = 0;
    int         killed = 0;
    int         cyc = 0;
    int         edges = 0;     // counts unblocked edges only.
    logic       stall_on = 1'b0;
    logic       intr_on = 1'b0;
    ex_result_t exp_q[$];
    int         stamp_q[$];
    logic       ex_v = 1'b0;   // shadow of the issue register.
    logic       seen_issue = 1'b0;
    issue_t     ex_it;
    int         ex_stamp;

    exec_top dut0 (.*);

    always #5 clk = ~clk;

    task automatic compare(input string name, input logic [CMP_W-1:0] want,
                           input logic [CMP_W-1:0] got);
        checks++;
        if (got !== want) begin
            errors++;
            $display("[FAIL] %s: expected %0h, actual %0h", name, want, got);
        end
    endtask

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fffffff) % n;
    endfunction

    // word mode narrows the operands so that the 64-bit operation gives the word answer.
    function automatic logic [`XLEN-1:0] alu_ref(input logic [`XLEN-1:0] a,
                                                 input logic [`XLEN-1:0] b,
                                                 input alu_op_e op, input logic w);
        logic [`XLEN-1:0] r;
        logic [5:0]       sh;
        sh = w ? {1'b0, b[4:0]} : b[5:0];
        if (w && (op == ALU_SRA || op == ALU_SLT)) begin
            a = {{32{a[31]}}, a[31:0]};
            b = {{32{b[31]}}, b[31:0]};
        end else if (w) begin
            a = {32'b0, a[31:0]};
            b = {32'b0, b[31:0]};
        end
        case (op)
            ALU_ADD:  r = a + b;
            ALU_SUB:  r = a - b;
            ALU_SLL:  r = a << sh;
            ALU_SLT:  r = {63'b0, $signed(a) < $signed(b)};
            ALU_SLTU: r = {63'b0, a < b};
            ALU_XOR:  r = a ^ b;
            ALU_SRL:  r = a >> sh;
            ALU_SRA:  r = $signed(a) >>> sh;
            ALU_OR:   r = a | b;
            ALU_AND:  r = a & b;
            default:  r = '0;
        endcase
        return w ? {{32{r[31]}}, r[31:0]} : r;
    endfunction

    function automatic ex_result_t expect_result(input issue_t it);
        ex_result_t       r;
        logic [`XLEN-1:0] imm64;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [2:0]       lane;
        logic             cond;
        imm64 = {{(`XLEN-`IMM_W){it.imm[`IMM_W-1]}}, it.imm};
        a = (it.a_sel == A_PC) ? it.pc : it.src1;
        b = (it.b_sel == B_IMM) ? imm64 : (it.b_sel == B_FOUR) ? `XLEN'd4 : it.src2;
        case (it.branch)
            BR_JAL, BR_JALR: cond = 1'b1;
            BR_BEQ:  cond = it.src1 == it.src2;
            BR_BNE:  cond = it.src1 != it.src2;
            BR_BLT:  cond = $signed(it.src1) < $signed(it.src2);
            BR_BGE:  cond = $signed(it.src1) >= $signed(it.src2);
            BR_BLTU: cond = it.src1 < it.src2;
            BR_BGEU: cond = it.src1 >= it.src2;
            default: cond = 1'b0;
        endcase
        r = '0;
        r.pc = it.pc;
        r.result = alu_ref(a, b, it.alu_op, it.is_word);
        r.taken = cond;
        r.next_pc = !cond ? it.pc + `XLEN'd4 :
                    (it.branch == BR_JALR) ? (it.src1 + imm64) & ~`XLEN'd1 : it.pc + imm64;
        {r.rd, r.reg_wr, r.mem_rd} = {it.rd, it.reg_wr, it.mem_rd};
        {r.mem_wr, r.ecall, r.error} = {it.mem_wr, it.ecall, it.error};
        lane = r.result[2:0];
        case (it.mem_size)
            MEM_B:   r.wmask = 8'h01 << lane;
            MEM_H:   r.wmask = 8'h03 << (lane & 3'b110);
            MEM_W:   r.wmask = 8'h0f << (lane & 3'b100);
            default: r.wmask = 8'hff;
        endcase
        r.wdata = (it.mem_size == MEM_B) ? {8{it.src2[7:0]}} :
                  (it.mem_size == MEM_H) ? {4{it.src2[15:0]}} :
                  (it.mem_size == MEM_W) ? {2{it.src2[31:0]}} : it.src2;
        return r;
    endfunction

    // kind 0 is ALU, 1 control flow, 2 store.
    function automatic issue_t make_item(input int kind, input int size, input int lane);
        issue_t it;
        it = '0;
        it.src1 = {$random(seed), $random(seed)};
        it.src2 = (rand_below(2) == 0) ? it.src1 : {$random(seed), $random(seed)};
        it.imm = $random(seed);
        it.pc = {$random(seed), $random(seed)} & ~`XLEN'd3;
        it.rd = 5'(rand_below(32));
        {it.mem_rd, it.reg_wr, it.error} = 3'(rand_below(8));
        it.ecall = rand_below(4) == 0;
        it.mem_size = mem_size_e'(2'(size));
        case (kind)
            0: begin
                it.a_sel = a_sel_e'(1'(rand_below(2)));
                it.b_sel = b_sel_e'(2'(rand_below(3)));
                it.alu_op = alu_op_e'(4'(rand_below(10)));
                it.is_word = 1'(rand_below(2));
            end
            1: begin
                it.branch = branch_e'(4'(1 + rand_below(8)));
                if (it.branch == BR_JAL || it.branch == BR_JALR) begin
                    it.a_sel = A_PC;
                    it.b_sel = B_FOUR;
                end else begin
                    it.alu_op = ALU_SUB;
                end
            end
            default: begin
                it.src1[2:0] = 3'b000;  // the low immediate bits then pick the lane.
                it.imm[2:0] = 3'(lane);
                it.b_sel = B_IMM;
                it.mem_wr = 1'b1;
            end
        endcase
        return it;
    endfunction

    task automatic step(output logic blk);
        blk = stall_on && rand_below(4) == 0;
        block <= blk;
        raise_intr <= intr_on && rand_below(3) == 0;
        @(posedge clk);
    endtask

    task automatic send(input issue_t it);
        logic blk;
        issue <= it;
        issue_valid <= 1'b1;
        sent++;
        do begin
            step(blk);
        end while (blk);
    endtask

    task automatic idle(input int n);
        logic blk;
        issue_valid <= 1'b0;
        repeat (n) step(blk);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic end_test();
        stall_on = 1'b0;
        intr_on = 1'b0;
        idle(6);
        $display("test %s finished with %0d errors", test_name, errors - err_start);
    endtask

    // the model follows the two registers on the same edges as the DUT.
    always @(posedge clk) begin
        cyc++;
        if (cyc > 1 && !seen_issue) compare("reset", CMP_W'(1'b0), CMP_W'(mem_valid));
        if (arst_n && !block) begin
            if (mem_valid && exp_q.size() == 0) begin
                errors++;
                $display("a result reached mem with no instruction expected, pc %0h", mem.pc);
            end else if (mem_valid) begin
                compare(test_name, exp_q.pop_front(), mem);
                compare({test_name, " latency"}, CMP_W'(2), CMP_W'(edges - stamp_q.pop_front()));
            end
            if (ex_v && (ex_it.ecall || !raise_intr)) begin
                exp_q.push_back(expect_result(ex_it));
                stamp_q.push_back(ex_stamp);
            end else if (ex_v) begin
                killed++;
            end
            ex_v = issue_valid;
            seen_issue = seen_issue || issue_valid;
            ex_it = issue;
            ex_stamp = edges;
            edges++;
        end
    end

    initial begin
        arst_n = 1'b0;
        block = 1'b0;
        issue_valid = 1'b0;
        issue = '0;
        raise_intr = 1'b0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        start_test("reset");
        end_test();
        start_test("alu");
        repeat (N_ALU) begin
            send(make_item(0, rand_below(4), 0));
            if (rand_below(4) == 0) idle(1);
        end
        end_test();
        start_test("control");
        repeat (N_CTRL) send(make_item(1, rand_below(4), 0));
        end_test();
        start_test("store");
        for (int s = 0; s < 4; s++) begin
            for (int l = 0; l < N_STORE / 4; l++) send(make_item(2, s, l));
        end
        end_test();
        start_test("stall");
        stall_on = 1'b1;
        repeat (N_STALL) send(make_item(rand_below(3), rand_below(4), rand_below(8)));
        end_test();
        start_test("interrupt");
        intr_on = 1'b1;
        repeat (N_INTR) send(make_item(rand_below(3), rand_below(4), rand_below(8)));
        end_test();
        if (exp_q.size() != 0) $display("%0d expected results never reached mem", exp_q.size());
        if (killed == 0) $display("the interrupt test killed no instruction");
        $display("tests 6, instructions %0d, killed %0d, checks %0d, errors %0d",
                 sent, killed, checks, errors);
        if (errors == 0 && killed != 0 && exp_q.size() == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        repeat (N_ISSUE * 20) @(posedge clk);
        $display("watchdog timeout, the tests did not end within %0d cycles", N_ISSUE * 20);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: flist.f
+incdir+rtl
rtl/rv_exec_pkg.sv
rtl/stage_reg.sv
rtl/int_alu.sv
rtl/branch_unit.sv
rtl/store_align.sv
rtl/exec_stage.sv
rtl/exec_top.sv
bench/exec_checker.sv
bench/exec_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module exec_tb -f flist.f
out=$(./obj_dir/Vexec_tb 2>&1) || true
echo "$out"
if echo "$out" | grep -qx '=== PASS ==='; then
    exit 0
fi
exit 1
